//--- verilog/isa_pkg.sv
package isa_pkg;

    localparam int xlen      = 32;  // Data and instruction word width
    localparam int reg_idx_w = 5;   // 32 architectural registers
    localparam int imm_w     = 17;  // Signed immediate, bits 16..0
    localparam int target_w  = 27;  // Jump target, bits 26..0

    // jal writes its return address here
    localparam logic [reg_idx_w-1:0] link_reg = 5'd31;

    // Primary opcode, bits 31..27
    typedef enum logic [4:0] {
        op_r_type = 5'b00000,
        op_j      = 5'b00001,
        op_bne    = 5'b00010,
        op_jal    = 5'b00011,
        op_jr     = 5'b00100,
        op_addi   = 5'b00101,
        op_blt    = 5'b00110,
        op_sw     = 5'b00111,
        op_lw     = 5'b01000
    } opcode_e;

    // R-type function, bits 6..2
    typedef enum logic [4:0] {
        alu_add = 5'b00000,
        alu_sub = 5'b00001,
        alu_and = 5'b00010,
        alu_or  = 5'b00011,
        alu_sll = 5'b00100,
        alu_sra = 5'b00101
    } alu_op_e;

endpackage

//--- verilog/core_pkg.sv
package core_pkg;

    localparam int addr_w     = 8;    // Word address into either memory
    localparam int imem_depth = 256;  // Instruction words
    localparam int dmem_depth = 256;  // Data words

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        fwd_reg = 2'd0,  // Value read in decode
        fwd_mem = 2'd1,  // Memory stage result
        fwd_wb  = 2'd2   // Write-back result
    } fwd_sel_e;

endpackage

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [isa_pkg::xlen-1:0]      a,
    input  logic [isa_pkg::xlen-1:0]      b,
    input  isa_pkg::alu_op_e              op,
    input  logic [isa_pkg::reg_idx_w-1:0] shamt,  // Shift count, bits 11..7
    output logic [isa_pkg::xlen-1:0]      result,
    output logic                          not_equal,
    output logic                          less_than
);

    always_comb begin
        case (op)
            isa_pkg::alu_add: result = a + b;               // Wraps mod 2^32
            isa_pkg::alu_sub: result = a - b;
            isa_pkg::alu_and: result = a & b;
            isa_pkg::alu_or:  result = a | b;
            isa_pkg::alu_sll: result = a << shamt;
            isa_pkg::alu_sra: result = $signed(a) >>> shamt; // Sign fill
            default:          result = '0;                  // Undefined function
        endcase
    end

    // Branch flags, a holds rd and b holds rs
    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b));

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                          clock,
    input  logic                          rst,
    input  logic [isa_pkg::reg_idx_w-1:0] rd_a,
    input  logic [isa_pkg::reg_idx_w-1:0] rd_b,
    input  logic                          wb_en,
    input  logic [isa_pkg::reg_idx_w-1:0] wb_reg,
    input  logic [isa_pkg::xlen-1:0]      wb_data,
    output logic [isa_pkg::xlen-1:0]      q_a,
    output logic [isa_pkg::xlen-1:0]      q_b
);

    logic [isa_pkg::xlen-1:0] regs [2**isa_pkg::reg_idx_w];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 2**isa_pkg::reg_idx_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_reg != '0) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // Write-through so decode sees this cycle's write-back
    assign q_a = (rd_a == '0) ? '0 : (wb_en && wb_reg == rd_a) ? wb_data : regs[rd_a];
    assign q_b = (rd_b == '0) ? '0 : (wb_en && wb_reg == rd_b) ? wb_data : regs[rd_b];

    // Write-back only ever names a real destination
    a_no_r0_write: assert property (@(posedge clock) disable iff (rst)
        wb_en |-> wb_reg != '0);

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        stall,        // Load-use hold from decode
    input  logic                        redirect,     // Taken branch or jump in execute
    input  logic [core_pkg::addr_w-1:0] redirect_pc,
    input  logic                        imem_we,
    input  logic [core_pkg::addr_w-1:0] imem_waddr,
    input  logic [isa_pkg::xlen-1:0]    imem_wdata,
    output logic [core_pkg::addr_w-1:0] f_pc,
    output logic [isa_pkg::xlen-1:0]    f_instr
);

    logic [isa_pkg::xlen-1:0] imem [core_pkg::imem_depth];

    // Redirect beats stall, stall beats sequential
    always_ff @(posedge clock) begin
        if (rst) begin
            f_pc <= '0;
        end else if (redirect) begin
            f_pc <= redirect_pc;
        end else if (!stall) begin
            f_pc <= f_pc + 1'b1;
        end
    end

    // Program is written only while the core sits in reset
    always_ff @(posedge clock) begin
        if (imem_we) begin
            imem[imem_waddr] <= imem_wdata;
        end
    end

    assign f_instr = imem[f_pc];  // Asynchronous read

    // A held decode must see the same fetch address and word when it resumes
    a_pc_hold: assert property (@(posedge clock) disable iff (rst)
        stall && !redirect |=> $stable(f_pc) && $stable(f_instr));

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                          clock,
    input  logic                          rst,
    input  logic [core_pkg::addr_w-1:0]   f_pc,
    input  logic [isa_pkg::xlen-1:0]      f_instr,
    input  logic                          redirect,
    input  logic                          x_load,   // Execute holds a lw
    input  logic [isa_pkg::reg_idx_w-1:0] x_rd,     // Its destination
    output logic                          stall,
    output logic [isa_pkg::reg_idx_w-1:0] rd_a,     // Register file read indices
    output logic [isa_pkg::reg_idx_w-1:0] rd_b,
    output logic [core_pkg::addr_w-1:0]   d_pc,
    output logic [isa_pkg::xlen-1:0]      d_instr,
    output logic [isa_pkg::reg_idx_w-1:0] d_src_a,  // Zero when the operand is unused
    output logic [isa_pkg::reg_idx_w-1:0] d_src_b
);

    isa_pkg::opcode_e              opcode;
    isa_pkg::alu_op_e              alu_op;
    logic [isa_pkg::reg_idx_w-1:0] rd;
    logic [isa_pkg::reg_idx_w-1:0] rs;
    logic [isa_pkg::reg_idx_w-1:0] rt;
    logic                          use_a;
    logic                          use_b;

    // F/D register, all-zero word is add r0 r0 r0
    always_ff @(posedge clock) begin
        if (rst || redirect) begin
            d_instr <= '0;            // Squash the younger fetch
        end else if (!stall) begin
            d_instr <= f_instr;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            d_pc <= f_pc;
        end
    end

    assign opcode = isa_pkg::opcode_e'(d_instr[31:27]);
    assign rd     = d_instr[26:22];
    assign rs     = d_instr[21:17];
    assign rt     = d_instr[16:12];
    assign alu_op = isa_pkg::alu_op_e'(d_instr[6:2]);

    // Branches, jr and sw carry their first operand in rd
    assign rd_a = (opcode inside {isa_pkg::op_bne, isa_pkg::op_blt, isa_pkg::op_jr,
                                  isa_pkg::op_sw}) ? rd : rs;
    assign rd_b = (opcode inside {isa_pkg::op_bne, isa_pkg::op_blt, isa_pkg::op_sw,
                                  isa_pkg::op_lw}) ? rs : rt;

    assign use_a = opcode inside {isa_pkg::op_r_type, isa_pkg::op_addi, isa_pkg::op_bne,
                                  isa_pkg::op_blt, isa_pkg::op_jr, isa_pkg::op_sw};
    // Shifts take shamt and ignore rt
    assign use_b = (opcode inside {isa_pkg::op_bne, isa_pkg::op_blt, isa_pkg::op_sw,
                                   isa_pkg::op_lw})
                || (opcode == isa_pkg::op_r_type
                    && alu_op inside {isa_pkg::alu_add, isa_pkg::alu_sub,
                                      isa_pkg::alu_and, isa_pkg::alu_or});

    assign d_src_a = use_a ? rd_a : '0;
    assign d_src_b = use_b ? rd_b : '0;

    // Load data arrives one stage too late for a direct consumer
    assign stall = x_load && (x_rd != '0) && (x_rd == d_src_a || x_rd == d_src_b);

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          stall,
    input  logic [core_pkg::addr_w-1:0]   d_pc,
    input  logic [isa_pkg::xlen-1:0]      d_instr,
    input  logic [isa_pkg::reg_idx_w-1:0] d_src_a,
    input  logic [isa_pkg::reg_idx_w-1:0] d_src_b,
    input  logic [isa_pkg::xlen-1:0]      q_a,
    input  logic [isa_pkg::xlen-1:0]      q_b,
    input  logic                          m_fwd_en,
    input  logic [isa_pkg::reg_idx_w-1:0] m_fwd_rd,
    input  logic [isa_pkg::xlen-1:0]      m_fwd_data,
    input  logic                          wb_en,
    input  logic [isa_pkg::reg_idx_w-1:0] wb_reg,
    input  logic [isa_pkg::xlen-1:0]      wb_data,
    output logic                          redirect,
    output logic [core_pkg::addr_w-1:0]   redirect_pc,
    output logic                          x_load,
    output logic [isa_pkg::reg_idx_w-1:0] x_rd,
    output logic [isa_pkg::xlen-1:0]      x_result,
    output logic [isa_pkg::xlen-1:0]      x_store_data,
    output isa_pkg::opcode_e              x_opcode,
    output logic [isa_pkg::reg_idx_w-1:0] x_dest     // Zero when nothing is written
);

    // D/X register
    logic [core_pkg::addr_w-1:0]   dx_pc;
    logic [isa_pkg::xlen-1:0]      dx_instr;
    logic [isa_pkg::reg_idx_w-1:0] dx_src_a;
    logic [isa_pkg::reg_idx_w-1:0] dx_src_b;
    logic [isa_pkg::xlen-1:0]      dx_q_a;
    logic [isa_pkg::xlen-1:0]      dx_q_b;

    isa_pkg::opcode_e              opcode;
    isa_pkg::alu_op_e              alu_op;
    logic [isa_pkg::reg_idx_w-1:0] rd;
    logic [isa_pkg::reg_idx_w-1:0] shamt;
    logic [isa_pkg::imm_w-1:0]     imm;
    logic [isa_pkg::target_w-1:0]  target;
    logic [isa_pkg::xlen-1:0]      imm_ext;
    core_pkg::fwd_sel_e            sel_a;
    core_pkg::fwd_sel_e            sel_b;
    logic [isa_pkg::xlen-1:0]      opnd_a;
    logic [isa_pkg::xlen-1:0]      opnd_b;
    logic [isa_pkg::xlen-1:0]      alu_a;
    logic [isa_pkg::xlen-1:0]      alu_b;
    isa_pkg::alu_op_e              alu_fn;
    logic [isa_pkg::xlen-1:0]      alu_result;
    logic                          not_equal;
    logic                          less_than;
    logic [core_pkg::addr_w-1:0]   link_pc;
    logic [core_pkg::addr_w-1:0]   br_target;

    always_ff @(posedge clock) begin
        if (rst || redirect || stall) begin
            dx_instr <= '0;  // Bubble
            dx_src_a <= '0;
            dx_src_b <= '0;
        end else begin
            dx_instr <= d_instr;
            dx_src_a <= d_src_a;
            dx_src_b <= d_src_b;
        end
    end

    always_ff @(posedge clock) begin
        dx_pc  <= d_pc;
        dx_q_a <= q_a;
        dx_q_b <= q_b;
    end

    assign opcode  = isa_pkg::opcode_e'(dx_instr[31:27]);
    assign rd      = dx_instr[26:22];
    assign shamt   = dx_instr[11:7];
    assign alu_op  = isa_pkg::alu_op_e'(dx_instr[6:2]);
    assign imm     = dx_instr[16:0];
    assign target  = dx_instr[26:0];
    assign imm_ext = {{(isa_pkg::xlen-isa_pkg::imm_w){imm[isa_pkg::imm_w-1]}}, imm};

    // Memory stage is younger, so it wins over write-back
    assign sel_a = (dx_src_a != '0 && m_fwd_en && m_fwd_rd == dx_src_a) ? core_pkg::fwd_mem :
                   (dx_src_a != '0 && wb_en && wb_reg == dx_src_a)      ? core_pkg::fwd_wb  :
                                                                          core_pkg::fwd_reg;
    assign sel_b = (dx_src_b != '0 && m_fwd_en && m_fwd_rd == dx_src_b) ? core_pkg::fwd_mem :
                   (dx_src_b != '0 && wb_en && wb_reg == dx_src_b)      ? core_pkg::fwd_wb  :
                                                                          core_pkg::fwd_reg;

    always_comb begin
        case (sel_a)
            core_pkg::fwd_mem: opnd_a = m_fwd_data;
            core_pkg::fwd_wb:  opnd_a = wb_data;
            default:           opnd_a = dx_q_a;
        endcase
        case (sel_b)
            core_pkg::fwd_mem: opnd_b = m_fwd_data;
            core_pkg::fwd_wb:  opnd_b = wb_data;
            default:           opnd_b = dx_q_b;
        endcase
    end

    // lw/sw base sits on port B, addi base on port A
    assign alu_a  = (opcode == isa_pkg::op_lw || opcode == isa_pkg::op_sw) ? opnd_b : opnd_a;
    assign alu_b  = (opcode inside {isa_pkg::op_addi, isa_pkg::op_lw, isa_pkg::op_sw})
                  ? imm_ext : opnd_b;
    assign alu_fn = (opcode == isa_pkg::op_r_type) ? alu_op : isa_pkg::alu_add;

    alu u_alu (
        .a(alu_a), .b(alu_b), .op(alu_fn), .shamt,
        .result(alu_result), .not_equal, .less_than
    );

    assign link_pc   = dx_pc + 1'b1;
    assign br_target = link_pc + imm_ext[core_pkg::addr_w-1:0];  // PC+1+imm

    always_comb begin
        redirect    = 1'b0;
        redirect_pc = br_target;
        case (opcode)
            isa_pkg::op_j, isa_pkg::op_jal: begin
                redirect    = 1'b1;
                redirect_pc = target[core_pkg::addr_w-1:0];
            end
            isa_pkg::op_jr: begin
                redirect    = 1'b1;
                redirect_pc = opnd_a[core_pkg::addr_w-1:0];  // Jump to rd
            end
            isa_pkg::op_bne: redirect = not_equal;
            isa_pkg::op_blt: redirect = less_than;
            default: ;
        endcase
    end

    always_comb begin
        case (opcode)
            isa_pkg::op_r_type: x_dest = (alu_op inside {isa_pkg::alu_add, isa_pkg::alu_sub,
                                          isa_pkg::alu_and, isa_pkg::alu_or,
                                          isa_pkg::alu_sll, isa_pkg::alu_sra}) ? rd : '0;
            isa_pkg::op_addi, isa_pkg::op_lw: x_dest = rd;
            isa_pkg::op_jal: x_dest = isa_pkg::link_reg;
            default: x_dest = '0;  // Stores, branches, jumps, no-ops
        endcase
    end

    assign x_result = (opcode == isa_pkg::op_jal)
                    ? {{(isa_pkg::xlen-core_pkg::addr_w){1'b0}}, link_pc} : alu_result;
    assign x_store_data = opnd_a;  // sw data comes from rd
    assign x_opcode = opcode;
    assign x_load   = (opcode == isa_pkg::op_lw);
    assign x_rd     = rd;

    // A lw never redirects, so a load-use stall cannot meet a redirect
    a_redirect_no_stall: assert property (@(posedge clock) disable iff (rst)
        redirect |-> !stall);

endmodule

//--- verilog/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic                          clock,
    input  logic                          rst,
    input  isa_pkg::opcode_e              x_opcode,
    input  logic [isa_pkg::reg_idx_w-1:0] x_dest,
    input  logic [isa_pkg::xlen-1:0]      x_result,      // ALU result, address or link
    input  logic [isa_pkg::xlen-1:0]      x_store_data,
    output logic                          dmem_we,
    output logic [core_pkg::addr_w-1:0]   dmem_addr,
    output logic [isa_pkg::xlen-1:0]      dmem_wdata,
    output logic                          m_fwd_en,
    output logic [isa_pkg::reg_idx_w-1:0] m_fwd_rd,
    output logic [isa_pkg::xlen-1:0]      m_fwd_data,
    output logic                          wb_en,
    output logic [isa_pkg::reg_idx_w-1:0] wb_reg,
    output logic [isa_pkg::xlen-1:0]      wb_data
);

    isa_pkg::opcode_e              xm_opcode;
    logic [isa_pkg::reg_idx_w-1:0] xm_dest;
    logic [isa_pkg::xlen-1:0]      xm_result;
    logic [isa_pkg::xlen-1:0]      xm_store_data;
    logic [isa_pkg::xlen-1:0]      dmem [core_pkg::dmem_depth];

    // X/M register
    always_ff @(posedge clock) begin
        if (rst) begin
            xm_opcode <= isa_pkg::op_r_type;
            xm_dest   <= '0;
        end else begin
            xm_opcode <= x_opcode;
            xm_dest   <= x_dest;
        end
    end

    always_ff @(posedge clock) begin
        xm_result     <= x_result;
        xm_store_data <= x_store_data;
    end

    assign dmem_we    = (xm_opcode == isa_pkg::op_sw);
    assign dmem_addr  = xm_result[core_pkg::addr_w-1:0];
    assign dmem_wdata = xm_store_data;

    always_ff @(posedge clock) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    // Memory stage result, load data picked here
    assign m_fwd_en   = (xm_dest != '0);
    assign m_fwd_rd   = xm_dest;
    assign m_fwd_data = (xm_opcode == isa_pkg::op_lw) ? dmem[dmem_addr] : xm_result;

    // M/W register
    always_ff @(posedge clock) begin
        if (rst) begin
            wb_reg <= '0;
        end else begin
            wb_reg <= xm_dest;
        end
    end

    always_ff @(posedge clock) begin
        wb_data <= m_fwd_data;
    end

    assign wb_en = (wb_reg != '0);  // r0 is never written

endmodule

//--- verilog/proc_top.sv
`timescale 1ns/1ps

module proc_top (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            imem_we,     // Program load, only during reset
    input  logic [core_pkg::addr_w-1:0]     imem_waddr,
    input  logic [isa_pkg::xlen-1:0]        imem_wdata,
    output logic                            wb_en,
    output logic [isa_pkg::reg_idx_w-1:0]   wb_reg,
    output logic [isa_pkg::xlen-1:0]        wb_data,
    output logic                            dmem_we,
    output logic [core_pkg::addr_w-1:0]     dmem_addr,
    output logic [isa_pkg::xlen-1:0]        dmem_wdata
);

    // Fetch to decode
    logic [core_pkg::addr_w-1:0]   f_pc;
    logic [isa_pkg::xlen-1:0]      f_instr;

    // Decode to register file and execute
    logic                          stall;
    logic [isa_pkg::reg_idx_w-1:0] rd_a;
    logic [isa_pkg::reg_idx_w-1:0] rd_b;
    logic [isa_pkg::xlen-1:0]      q_a;
    logic [isa_pkg::xlen-1:0]      q_b;
    logic [core_pkg::addr_w-1:0]   d_pc;
    logic [isa_pkg::xlen-1:0]      d_instr;
    logic [isa_pkg::reg_idx_w-1:0] d_src_a;
    logic [isa_pkg::reg_idx_w-1:0] d_src_b;

    // Execute outputs
    logic                          redirect;
    logic [core_pkg::addr_w-1:0]   redirect_pc;
    logic                          x_load;
    logic [isa_pkg::reg_idx_w-1:0] x_rd;
    logic [isa_pkg::xlen-1:0]      x_result;
    logic [isa_pkg::xlen-1:0]      x_store_data;
    isa_pkg::opcode_e              x_opcode;
    logic [isa_pkg::reg_idx_w-1:0] x_dest;

    // Memory stage bypass
    logic                          m_fwd_en;
    logic [isa_pkg::reg_idx_w-1:0] m_fwd_rd;
    logic [isa_pkg::xlen-1:0]      m_fwd_data;

    fetch_stage u_fetch (
        .clock, .rst, .stall, .redirect, .redirect_pc,
        .imem_we, .imem_waddr, .imem_wdata,
        .f_pc, .f_instr
    );

    decode_stage u_decode (
        .clock, .rst, .f_pc, .f_instr, .redirect, .x_load, .x_rd,
        .stall, .rd_a, .rd_b, .d_pc, .d_instr, .d_src_a, .d_src_b
    );

    reg_file u_regs (
        .clock, .rst, .rd_a, .rd_b, .wb_en, .wb_reg, .wb_data,
        .q_a, .q_b
    );

    execute_stage u_execute (
        .clock, .rst, .stall, .d_pc, .d_instr, .d_src_a, .d_src_b, .q_a, .q_b,
        .m_fwd_en, .m_fwd_rd, .m_fwd_data, .wb_en, .wb_reg, .wb_data,
        .redirect, .redirect_pc, .x_load, .x_rd,
        .x_result, .x_store_data, .x_opcode, .x_dest
    );

    mem_wb_stage u_mem_wb (
        .clock, .rst, .x_opcode, .x_dest, .x_result, .x_store_data,
        .dmem_we, .dmem_addr, .dmem_wdata,
        .m_fwd_en, .m_fwd_rd, .m_fwd_data,
        .wb_en, .wb_reg, .wb_data
    );

endmodule

//--- tests/tb_proc.sv
`timescale 1ns/1ps

module tb_proc;

    localparam int reset_cycles   = 16;   // Minimum reset length per test
    localparam int timeout_cycles = 300;  // Budget for all expected events of one test
    localparam int drain_cycles   = 30;   // Quiet window after the last expected event

    logic        clock;
    logic        rst;
    logic        imem_we;
    logic [7:0]  imem_waddr;
    logic [31:0] imem_wdata;
    logic        wb_en;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic        dmem_we;
    logic [7:0]  dmem_addr;
    logic [31:0] dmem_wdata;

    // One test's program and expected events, filled from the vectors file
    logic [7:0]  p_addr [$];
    logic [31:0] p_word [$];
    logic [4:0]  w_reg  [$];
    logic [31:0] w_data [$];
    logic [7:0]  s_addr [$];
    logic [31:0] s_data [$];

    int          fd;
    string       line;
    byte         kind;                 // First character of a vectors line
    int          fields;
    logic [31:0] val_a;
    logic [31:0] val_b;
    int          test_id;
    int          w_idx;                // Next expected register write
    int          s_idx;                // Next expected store
    int          test_errors;
    int          tests_ok;
    int          tests_bad;
    int          file_errors;

    proc_top DUT (
        .clock, .rst, .imem_we, .imem_waddr, .imem_wdata,
        .wb_en, .wb_reg, .wb_data, .dmem_we, .dmem_addr, .dmem_wdata
    );

    always #5 clock = ~clock;  // 10 ns period

    // Compare this cycle's write-back and store against the next expected ones
    task automatic check_events();
        if ($isunknown({wb_en, dmem_we})) begin
            $display("Write enable went unknown at %0t in test %0d", $time, test_id);
            test_errors++;
        end
        if (wb_en === 1'b1) begin
            if (w_idx >= w_reg.size()) begin
                $display("Unexpected register write r%0d = %h at %0t in test %0d",
                         wb_reg, wb_data, $time, test_id);
                test_errors++;
            end else begin
                if (wb_reg !== w_reg[w_idx]) begin
                    $display("Fail %0t wb_reg expected %0d got %0d", $time, w_reg[w_idx], wb_reg);
                    test_errors++;
                end
                if (wb_data !== w_data[w_idx]) begin
                    $display("Fail %0t wb_data expected %h got %h", $time, w_data[w_idx], wb_data);
                    test_errors++;
                end
                w_idx++;
            end
        end
        if (dmem_we === 1'b1) begin
            if (s_idx >= s_addr.size()) begin
                $display("Unexpected store of %h to address %h at %0t in test %0d",
                         dmem_wdata, dmem_addr, $time, test_id);
                test_errors++;
            end else begin
                if (dmem_addr !== s_addr[s_idx]) begin
                    $display("Fail %0t dmem_addr expected %h got %h", $time, s_addr[s_idx],
                             dmem_addr);
                    test_errors++;
                end
                if (dmem_wdata !== s_data[s_idx]) begin
                    $display("Fail %0t dmem_wdata expected %h got %h", $time, s_data[s_idx],
                             dmem_wdata);
                    test_errors++;
                end
                s_idx++;
            end
        end
    endtask

    // Reset, load the program, then follow the expected event stream
    task automatic run_test();
        int pi;
        int cyc;
        pi = 0;
        test_errors = 0;
        w_idx = 0;
        s_idx = 0;
        // One program word per reset cycle, reset stretched for long programs
        for (cyc = 0; cyc < reset_cycles || pi < p_addr.size(); cyc++) begin
            @(posedge clock);
            #1;
            rst = 1'b1;
            imem_we = (pi < p_addr.size());
            if (imem_we) begin
                imem_waddr = p_addr[pi];
                imem_wdata = p_word[pi];
                pi++;
            end
        end
        @(posedge clock);  // Last word lands, still in reset
        #1;
        rst     = 1'b0;
        imem_we = 1'b0;
        cyc = 0;
        while ((w_idx < w_reg.size() || s_idx < s_addr.size()) && cyc < timeout_cycles) begin
            @(negedge clock);  // Outputs settled mid-cycle
            check_events();
            cyc++;
        end
        if (w_idx < w_reg.size() || s_idx < s_addr.size()) begin
            $display("Test %0d timed out: %0d of %0d writes and %0d of %0d stores seen",
                     test_id, w_idx, w_reg.size(), s_idx, s_addr.size());
            test_errors++;
        end else begin
            for (cyc = 0; cyc < drain_cycles; cyc++) begin
                @(negedge clock);
                check_events();  // Anything here is unexpected
            end
        end
        if (test_errors == 0) begin
            $display("Test %0d: ok", test_id);
            tests_ok++;
        end else begin
            $display("Test %0d: %0d errors", test_id, test_errors);
            tests_bad++;
        end
    endtask

    task automatic clear_test();
        p_addr.delete();
        p_word.delete();
        w_reg.delete();
        w_data.delete();
        s_addr.delete();
        s_data.delete();
    endtask

    initial begin
        clock       = 1'b0;
        rst         = 1'b1;
        imem_we     = 1'b0;
        imem_waddr  = '0;
        imem_wdata  = '0;
        test_id     = -1;
        tests_ok    = 0;
        tests_bad   = 0;
        file_errors = 0;
        fd = $fopen("tests/prog_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vectors file tests/prog_vectors.txt");
            file_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%c %h %h", kind, val_a, val_b);
                case (kind)
                    "T": begin
                        if (test_id >= 0) run_test();  // Previous test is complete
                        clear_test();
                        test_id = val_a;
                    end
                    "P", "W", "S": begin
                        if (fields != 3 || test_id < 0) begin
                            $display("Malformed vectors line: %s", line);
                            file_errors++;
                        end else if (kind == "P") begin
                            p_addr.push_back(val_a[7:0]);
                            p_word.push_back(val_b);
                        end else if (kind == "W") begin
                            w_reg.push_back(val_a[4:0]);
                            w_data.push_back(val_b);
                        end else begin
                            s_addr.push_back(val_a[7:0]);
                            s_data.push_back(val_b);
                        end
                    end
                    default: ;  // Comments and blank lines
                endcase
            end
            if (test_id >= 0) run_test();
            $fclose(fd);
        end
        $display("Summary: %0d tests ok, %0d tests with errors, %0d file errors",
                 tests_ok, tests_bad, file_errors);
        if (tests_bad == 0 && file_errors == 0 && tests_ok > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- sources.f
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/proc_top.sv
tests/tb_proc.sv

//--- tests/prog_vectors.txt
# T id | P imem_addr instr_word | W reg data | S dmem_addr data  (all hex)
# W and S lines list expected events in program order
# Test 1: R-type ops, negative addi, write to r0, wrap
T 1
P 00 2841fffb
P 01 28800003
P 02 00c22000
P 03 01041004
P 04 01422008
P 05 0182200c
P 06 01c20210
P 07 02020094
P 08 00022000
P 09 2a420006
P 0a 0800000a
W 01 fffffffb
W 02 00000003
W 03 fffffffe
W 04 00000008
W 05 00000003
W 06 fffffffb
W 07 ffffffb0
W 08 fffffffd
W 09 00000001
# Test 2: bypass from memory and write-back, same register in both
T 2
P 00 2840000a
P 01 28400014
P 02 00821000
P 03 00c41000
P 04 01062004
P 05 01483000
P 06 08000006
W 01 0000000a
W 01 00000014
W 02 00000028
W 03 0000003c
W 04 00000014
W 05 00000050
# Test 3: load followed at once by its user
T 3
P 00 28401234
P 01 28800010
P 02 38440004
P 03 40c40004
P 04 01063000
P 05 41440004
P 06 298a0001
P 07 08000007
W 01 00001234
W 02 00000010
S 14 00001234
W 03 00001234
W 04 00002468
W 05 00001234
W 06 00001235
# Test 4: stores of freshly written data
T 4
P 00 28400028
P 01 2881ffff
P 02 38820003
P 03 28c00007
P 04 38c3fffe
P 05 01043004
P 06 39020000
P 07 08000007
W 01 00000028
W 02 ffffffff
S 2b ffffffff
W 03 00000007
S 26 00000007
W 04 fffffff8
S 28 fffffff8
# Test 5: bne, blt taken and untaken, jal, jr, j
T 5
P 00 28400005
P 01 28800003
P 02 10440002
P 03 2a800001
P 04 2ac00001
P 05 30820002
P 06 2b000001
P 07 2b400001
P 08 30440002
P 09 10420001
P 0a 28c00009
P 0b 1800000e
P 0c 2b800001
P 0d 2bc00001
P 0e 293e0006
P 0f 21000000
P 10 2c000001
P 11 2c400001
P 12 29480001
P 13 08000013
W 01 00000005
W 02 00000003
W 03 00000009
W 1f 0000000c
W 04 00000012
W 05 00000013
